// File: design/dab_config.svh
/* Register map and counter width of the DAB modulator.
   Included by the package and by every module that addresses the generator. */
`ifndef DAB_CONFIG_SVH
`define DAB_CONFIG_SVH

// Control word of the generator sits on the base address itself
`define DAB_BASE_ADDR 32'h43c0_0000

// Chain c owns the window starting at base + (c+1) strides
`define DAB_CHAIN_STRIDE 32'h0000_0100

// Offsets inside one chain window place compare j at cmp + 4*j
`define DAB_CMP_OFFSET 32'h0000_0000
`define DAB_PERIOD_OFFSET 32'h0000_001c
`define DAB_PHASE_OFFSET 32'h0000_0020

`define DAB_COUNTER_WIDTH 16

`endif

// File: design/dab_modulator_top.sv
/* Top level of the DAB modulation subsystem. Joins the timing calculator,
   the operating core and the PWM generator over the internal write bus. */
`timescale 1ns/1ns
`include "dab_config.svh"

module dab_modulator_top (
    input  logic clock,
    input  logic reset,
    input  logic start,
    input  logic stop,
    input  logic update,
    input  logic [1:0] modulation_type,
    input  logic [`DAB_COUNTER_WIDTH-1:0] period,
    input  logic signed [`DAB_COUNTER_WIDTH-1:0] phase_shift_1,
    input  logic signed [`DAB_COUNTER_WIDTH-1:0] phase_shift_2,
    output logic modulator_status,
    output logic [3:0] gates
);
    import dab_pkg::*;

    compare_set_t compare;
    logic [`DAB_COUNTER_WIDTH-1:0] chain1_phase;

    reg_write_if write_bus ();

    dab_timing_calc timing (
        .clock(clock),
        .reset(reset),
        .modulation_type(modulation_type),
        .period(period),
        .phase_shift_1(phase_shift_1),
        .phase_shift_2(phase_shift_2),
        .compare(compare),
        .chain1_phase(chain1_phase)
    );

    dab_operating_core core (
        .clock(clock),
        .reset(reset),
        .start(start),
        .stop(stop),
        .update(update),
        .period(period),
        .compare(compare),
        .chain1_phase(chain1_phase),
        .modulator_status(modulator_status),
        .bus(write_bus.master)
    );

    pwm_generator generator (
        .clock(clock),
        .reset(reset),
        .bus(write_bus.slave),
        .gates(gates)
    );

endmodule

// File: design/dab_operating_core.sv
/* Sequencer that turns start, stop and update requests into register write
   series towards the PWM generator and reports the modulator status. */
`timescale 1ns/1ns
`include "dab_config.svh"

module dab_operating_core (
    input  logic clock,
    input  logic reset,
    input  logic start,
    input  logic stop,
    input  logic update,
    input  logic [`DAB_COUNTER_WIDTH-1:0] period,
    input  dab_pkg::compare_set_t compare,
    input  logic [`DAB_COUNTER_WIDTH-1:0] chain1_phase,
    output logic modulator_status,
    reg_write_if.master bus
);
    import dab_pkg::*;

    operating_state_t state;
    operating_state_t return_state;
    logic chain;
    logic [1:0] cmp_index;
    logic start_needed;
    logic stop_latched;
    pwm_ctrl_u run_ctrl;

    function automatic logic [31:0] window_base(input logic chain_sel);
        return `DAB_BASE_ADDR + (32'(chain_sel) + 32'd1) * `DAB_CHAIN_STRIDE;
    endfunction

    always_comb begin
        run_ctrl.raw = '0;
        run_ctrl.fields.enable = 2'b11;
    end

    ////////////////////////////////////////////////////////////
    // Write sequencer
    ////////////////////////////////////////////////////////////

    // Each write state presents one word, write_end waits for its acceptance
    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
            return_state <= idle;
            chain <= 1'b0;
            cmp_index <= 2'd0;
            start_needed <= 1'b0;
            stop_latched <= 1'b0;
            modulator_status <= 1'b0;
            bus.valid <= 1'b0;
        end else begin
            if (stop) begin
                stop_latched <= 1'b1;
            end
            case (state)
                idle: begin
                    if (stop_latched) begin
                        bus.dest <= `DAB_BASE_ADDR;
                        bus.data <= '0;
                        bus.valid <= 1'b1;
                        modulator_status <= 1'b0;
                        stop_latched <= 1'b0;
                        return_state <= idle;
                        state <= write_end;
                    end else if (start) begin
                        start_needed <= 1'b1;
                        state <= calc_wait;
                    end else if (update && modulator_status) begin
                        start_needed <= 1'b0;
                        state <= calc_wait;
                    end
                end
                calc_wait: begin
                    chain <= 1'b0;
                    cmp_index <= 2'd0;
                    state <= update_period;
                end
                update_period: begin
                    bus.dest <= window_base(chain) + `DAB_PERIOD_OFFSET;
                    bus.data <= data_word_t'(period);
                    bus.valid <= 1'b1;
                    chain <= ~chain;
                    return_state <= chain ? update_phase : update_period;
                    state <= write_end;
                end
                update_phase: begin
                    // Chain 0 is the reference and always starts at zero
                    bus.dest <= window_base(chain) + `DAB_PHASE_OFFSET;
                    bus.data <= chain ? data_word_t'(chain1_phase) : '0;
                    bus.valid <= 1'b1;
                    chain <= ~chain;
                    return_state <= chain ? update_compare : update_phase;
                    state <= write_end;
                end
                update_compare: begin
                    bus.dest <= window_base(chain) + `DAB_CMP_OFFSET
                        + 32'(cmp_index) * 32'd4;
                    bus.data <= data_word_t'(compare[{chain, cmp_index}]);
                    bus.valid <= 1'b1;
                    cmp_index <= cmp_index + 2'd1;
                    if (cmp_index == 2'd3) begin
                        chain <= ~chain;
                    end
                    if (cmp_index != 2'd3 || !chain) begin
                        return_state <= update_compare;
                    end else if (start_needed) begin
                        return_state <= start_modulator;
                    end else begin
                        return_state <= idle;
                    end
                    state <= write_end;
                end
                start_modulator: begin
                    bus.dest <= `DAB_BASE_ADDR;
                    bus.data <= run_ctrl.raw;
                    bus.valid <= 1'b1;
                    modulator_status <= 1'b1;
                    start_needed <= 1'b0;
                    return_state <= idle;
                    state <= write_end;
                end
                write_end: begin
                    if (bus.ready) begin
                        bus.valid <= 1'b0;
                        state <= return_state;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // Every write series must land inside the control word or a chain window
    assert property (@(posedge clock) disable iff (!reset)
        $rose(bus.valid) |-> (bus.dest >= `DAB_BASE_ADDR
            && bus.dest < `DAB_BASE_ADDR + 32'd3 * `DAB_CHAIN_STRIDE));

endmodule

// File: design/dab_pkg.sv
/* Types shared by the DAB modulator blocks: bus data word, generator
   control word, sequencer states and the compare set. */
`include "dab_config.svh"

package dab_pkg;

    typedef logic [31:0] data_word_t;

    typedef struct packed {
        logic [29:0] reserved;
        logic [1:0]  enable;
    } pwm_ctrl_fields_t;

    // The control register is either a raw bus word or a set of enable bits
    typedef union packed {
        data_word_t       raw;
        pwm_ctrl_fields_t fields;
    } pwm_ctrl_u;

    typedef enum logic [2:0] {
        idle,
        calc_wait,
        update_period,
        update_phase,
        update_compare,
        start_modulator,
        write_end
    } operating_state_t;

    typedef logic [`DAB_COUNTER_WIDTH-1:0] compare_set_t [8];

endpackage

// File: design/dab_timing_calc.sv
/* Works out the chain-1 phase and the eight compare values from the
   switching period and phase shifts, one cycle after its inputs. */
`timescale 1ns/1ns
`include "dab_config.svh"

module dab_timing_calc (
    input  logic clock,
    input  logic reset,
    input  logic [1:0] modulation_type,
    input  logic [`DAB_COUNTER_WIDTH-1:0] period,
    input  logic signed [`DAB_COUNTER_WIDTH-1:0] phase_shift_1,
    input  logic signed [`DAB_COUNTER_WIDTH-1:0] phase_shift_2,
    output dab_pkg::compare_set_t compare,
    output logic [`DAB_COUNTER_WIDTH-1:0] chain1_phase
);
    localparam int W = `DAB_COUNTER_WIDTH;

    logic signed [W+1:0] s_period;
    logic signed [W+1:0] half;
    logic signed [W+1:0] quarter;
    logic signed [W+1:0] inner;
    logic signed [W+1:0] shifted;
    logic signed [W+1:0] cmp_value [4];

    always_comb begin
        s_period = $signed({2'b00, period});
        half = s_period / 2;
        quarter = s_period / 4;
        if (modulation_type != 2'd0) begin
            inner = phase_shift_2 / 2;
        end else begin
            inner = '0;
        end
        // Falling edges sit exactly half a period after the rising ones
        cmp_value[0] = quarter - inner;
        cmp_value[1] = quarter + inner;
        cmp_value[2] = quarter + half - inner;
        cmp_value[3] = quarter + half + inner;
        shifted = half + phase_shift_1;
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            chain1_phase <= '0;
            for (int i = 0; i < 8; i++) begin
                compare[i] <= '0;
            end
        end else begin
            if (shifted < 0) begin
                chain1_phase <= '0;
            end else if (shifted > s_period) begin
                chain1_phase <= period;
            end else begin
                chain1_phase <= shifted[W-1:0];
            end
            for (int i = 0; i < 8; i++) begin
                compare[i] <= cmp_value[i % 4][W-1:0];
            end
        end
    end

endmodule

// File: design/pwm_generator.sv
/* Two-chain PWM generator. Register writes set period, phase and compares
   per chain, and the control word starts the carriers that drive the gates. */
`timescale 1ns/1ns
`include "dab_config.svh"

module pwm_generator (
    input  logic clock,
    input  logic reset,
    reg_write_if.slave bus,
    output logic [3:0] gates
);
    import dab_pkg::*;

    localparam int W = `DAB_COUNTER_WIDTH;

    logic write_en;
    logic ctrl_write;
    pwm_ctrl_u ctrl;
    pwm_ctrl_u ctrl_in;
    logic [W-1:0] period_reg [2];
    logic [W-1:0] phase_reg [2];
    compare_set_t cmp_reg;
    logic [W-1:0] carrier [2];
    logic [W-1:0] start_value [2];

    function automatic logic [31:0] chain_addr(input int c, input logic [31:0] offset);
        return `DAB_BASE_ADDR + 32'(c + 1) * `DAB_CHAIN_STRIDE + offset;
    endfunction

    assign bus.ready = 1'b1;
    assign write_en = bus.valid && bus.ready;
    assign ctrl_write = write_en && bus.dest == `DAB_BASE_ADDR;
    assign ctrl_in.raw = bus.data;

    always_ff @(posedge clock) begin
        if (write_en) begin
            for (int c = 0; c < 2; c++) begin
                if (bus.dest == chain_addr(c, `DAB_PERIOD_OFFSET)) begin
                    period_reg[c] <= bus.data[W-1:0];
                end
                if (bus.dest == chain_addr(c, `DAB_PHASE_OFFSET)) begin
                    phase_reg[c] <= bus.data[W-1:0];
                end
                for (int j = 0; j < 4; j++) begin
                    if (bus.dest == chain_addr(c, `DAB_CMP_OFFSET + 32'(j) * 32'd4)) begin
                        cmp_reg[4*c+j] <= bus.data[W-1:0];
                    end
                end
            end
        end
    end

    // The phase is a delay, so the carrier starts that far before its wrap
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            if (phase_reg[c] == '0 || phase_reg[c] >= period_reg[c]) begin
                start_value[c] = '0;
            end else begin
                start_value[c] = period_reg[c] - phase_reg[c];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Carriers and comparators
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset) begin
            ctrl.raw <= '0;
            for (int c = 0; c < 2; c++) begin
                carrier[c] <= '0;
            end
        end else begin
            if (ctrl_write) begin
                ctrl.raw <= ctrl_in.raw;
            end
            for (int c = 0; c < 2; c++) begin
                if (ctrl_write && ctrl_in.fields.enable[c]) begin
                    carrier[c] <= start_value[c];
                end else if (!ctrl.fields.enable[c] || carrier[c] >= period_reg[c] - 1'b1) begin
                    carrier[c] <= '0;
                end else begin
                    carrier[c] <= carrier[c] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int c = 0; c < 2; c++) begin
            gates[2*c] = ctrl.fields.enable[c] && carrier[c] >= cmp_reg[4*c]
                && carrier[c] < cmp_reg[4*c+2];
            gates[2*c+1] = ctrl.fields.enable[c] && carrier[c] >= cmp_reg[4*c+1]
                && carrier[c] < cmp_reg[4*c+3];
        end
    end

    // A chain may only be started once the core has written its period
    for (genvar c = 0; c < 2; c++) begin : g_period_check
        assert property (@(posedge clock) disable iff (!reset)
            ctrl_write && ctrl_in.fields.enable[c] |-> period_reg[c] != '0);
    end

endmodule

// File: design/reg_write_if.sv
/* Internal register write bus with a valid/ready handshake.
   The operating core is the master, the PWM generator the slave. */
`timescale 1ns/1ns

interface reg_write_if;
    import dab_pkg::*;

    logic [31:0] dest;
    data_word_t  data;
    logic        valid;
    logic        ready;

    modport master (
        output dest,
        output data,
        output valid,
        input  ready
    );

    modport slave (
        input  dest,
        input  data,
        input  valid,
        output ready
    );
endinterface

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the DAB modulator testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f verilog.f --top-module dab_modulator_tb \
    -Mdir obj_dir -o dab_modulator_sim

./obj_dir/dab_modulator_sim | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: test/clock_gen.sv
/* Testbench clock of 40 ns period, with the active-low reset held for two cycles. */
`timescale 1ns/1ns

module clock_gen (
    output logic clock,
    output logic reset
);
    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    initial begin
        reset = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
    end
endmodule

// File: test/dab_modulator_tb.sv
/* Table-driven testbench of the DAB modulator. Each row applies start, update or
   stop, then measures gate high times and edge delays over whole periods. */
`timescale 1ns/1ns
`include "dab_config.svh"

module dab_modulator_tb;
    import dab_pkg::*;

    localparam int act_start = 0;
    localparam int act_update = 1;
    localparam int act_stop = 2;
    localparam int num_rows = 10;

    typedef struct packed {
        int action;
        int period;
        int shift_1;
        int shift_2;
        int mod_type;
        logic [3:0][15:0] high_time;
        int chain1_delay;
        int gate1_offset;
    } row_t;

    logic clock;
    logic reset;
    logic start;
    logic stop;
    logic update;
    logic [1:0] modulation_type;
    logic [`DAB_COUNTER_WIDTH-1:0] period;
    logic signed [`DAB_COUNTER_WIDTH-1:0] phase_shift_1;
    logic signed [`DAB_COUNTER_WIDTH-1:0] phase_shift_2;
    logic modulator_status;
    logic [3:0] gates;

    row_t table_rows [num_rows];
    logic [3:0] trace [$];
    int cycle_limit;

    clock_gen clocks (.clock(clock), .reset(reset));

    dab_modulator_top DUT (
        .clock(clock),
        .reset(reset),
        .start(start),
        .stop(stop),
        .update(update),
        .modulation_type(modulation_type),
        .period(period),
        .phase_shift_1(phase_shift_1),
        .phase_shift_2(phase_shift_2),
        .modulator_status(modulator_status),
        .gates(gates)
    );

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            report_failure($sformatf("error %s: got 0x%h, expected 0x%h",
                name, actual, expected));
        end
    endtask

    task automatic check_count(input string name, input data_word_t actual,
                               input data_word_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("error %s: got 0x%h, expected 0x%h",
                name, actual, expected));
        end
    endtask

    // Expected timing follows the modulator rules, with chain 1 delayed by the clamped phase
    task automatic fill_row(input int idx, input int action, input int p, input int s1,
                            input int s2, input int mt);
        int phase;
        int inner;
        phase = p / 2 + s1;
        if (phase < 0) begin
            phase = 0;
        end else if (phase > p) begin
            phase = p;
        end
        inner = (mt != 0) ? s2 / 2 : 0;
        table_rows[idx].action = action;
        table_rows[idx].period = p;
        table_rows[idx].shift_1 = s1;
        table_rows[idx].shift_2 = s2;
        table_rows[idx].mod_type = mt;
        for (int g = 0; g < 4; g++) begin
            table_rows[idx].high_time[g] = 16'((action == act_stop) ? 0 : p / 2);
        end
        table_rows[idx].chain1_delay = phase % p;
        table_rows[idx].gate1_offset = (2 * inner + p) % p;
    endtask

    function automatic int find_rise(input int g, input int from);
        int found;
        found = -1;
        for (int i = from; i < trace.size() && found < 0; i++) begin
            if (trace[i][g] && !trace[i-1][g]) begin
                found = i;
            end
        end
        return found;
    endfunction

    task automatic check_edge(input int g, input int t0, input int expected, input string name);
        int t;
        t = find_rise(g, t0);
        if (t < 0) begin
            report_failure($sformatf("gate %0d never rose within the measurement window", g));
        end else begin
            check_count(name, data_word_t'(t - t0), data_word_t'(expected));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Row execution
    ////////////////////////////////////////////////////////////

    task automatic run_row(input row_t row);
        logic expected_status;
        int window;
        int high;
        int t0;
        expected_status = row.action != act_stop;
        window = expected_status ? row.period : 2 * row.period;
        @(negedge clock);
        period = 16'(row.period);
        phase_shift_1 = 16'(row.shift_1);
        phase_shift_2 = 16'(row.shift_2);
        modulation_type = 2'(row.mod_type);
        start = row.action == act_start;
        update = row.action == act_update;
        stop = row.action == act_stop;
        @(negedge clock);
        start = 1'b0;
        update = 1'b0;
        stop = 1'b0;
        while (modulator_status !== expected_status) begin
            @(negedge clock);
        end
        // Status must hold while the write series settles and the gates are traced
        repeat (2 * row.period) begin
            @(negedge clock);
            check_bit("modulator_status", modulator_status, expected_status);
        end
        trace.delete();
        repeat (2 * row.period + 1) begin
            @(negedge clock);
            check_bit("modulator_status", modulator_status, expected_status);
            trace.push_back(gates);
        end
        for (int g = 0; g < 4; g++) begin
            high = 0;
            for (int i = 1; i <= window; i++) begin
                high += int'(trace[i][g]);
            end
            check_count($sformatf("gates[%0d] high time", g), data_word_t'(high),
                data_word_t'(row.high_time[g]));
        end
        if (expected_status) begin
            t0 = find_rise(0, 1);
            if (t0 < 0) begin
                report_failure("gate 0 never rose within the measurement window");
            end else begin
                check_edge(1, t0, row.gate1_offset, "gates[1] rise offset");
                if (row.action == act_start) begin
                    check_edge(2, t0, row.chain1_delay, "gates[2] chain 1 delay");
                end
            end
        end
    endtask

    initial begin
        int cycle_count;
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        report_failure($sformatf("timeout, the run went past %0d clock cycles", cycle_limit));
    end

    initial begin
        int max_period;
        int p;
        int s1;
        int s2;
        int mt;
        start = 1'b0;
        stop = 1'b0;
        update = 1'b0;
        modulation_type = 2'd0;
        period = '0;
        phase_shift_1 = '0;
        phase_shift_2 = '0;
        cycle_limit = 0;
        void'($urandom(32'hc51f));
        fill_row(0, act_start, 128, 20, 0, 0);
        fill_row(1, act_start, 128, -30, 16, 1);
        fill_row(2, act_start, 100, 80, 40, 0);
        fill_row(3, act_start, 160, -100, 30, 3);
        fill_row(4, act_update, 200, 0, 20, 1);
        fill_row(5, act_stop, 200, 0, 20, 1);
        fill_row(6, act_start, 96, 10, -12, 2);
        for (int r = 7; r < num_rows; r++) begin
            p = int'($urandom_range(255, 64));
            s1 = int'($urandom_range(2 * p, 0)) - p;
            s2 = int'($urandom_range(p / 2, 0)) - p / 4;
            mt = int'($urandom_range(3, 0));
            fill_row(r, act_start, p, s1, s2, mt);
        end
        max_period = 0;
        for (int r = 0; r < num_rows; r++) begin
            if (table_rows[r].period > max_period) begin
                max_period = table_rows[r].period;
            end
        end
        cycle_limit = num_rows * (40 + 4 * max_period);
        wait (reset === 1'b1);
        for (int r = 0; r < num_rows; r++) begin
            run_row(table_rows[r]);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+design
design/dab_pkg.sv
design/reg_write_if.sv
design/dab_timing_calc.sv
design/dab_operating_core.sv
design/pwm_generator.sv
design/dab_modulator_top.sv
test/clock_gen.sv
test/dab_modulator_tb.sv
